//--- verilog/video_pkg.sv
// Video side definitions
// Stream pixel word, luma sample and frame dimension types
// Block geometry constants and the register map
package video_pkg;

	// Stream word, top byte unused
	typedef logic [31:0] pixel_t;

	// One reduced sample per pixel
	typedef logic [7:0] luma_t;

	typedef logic [15:0] dim_t;
	typedef logic [31:0] block_count_t;
	typedef logic [0:0] reg_addr_t;

	// Byte lanes inside a pixel word
	localparam int blue_lsb = 0;
	localparam int green_lsb = 8;
	localparam int red_lsb = 16;
	localparam int channel_width = 8;

	// Block geometry
	localparam int block_size = 8;
	localparam int samples_per_block = block_size * block_size;
	localparam int block_shift = $clog2(samples_per_block);

	// Register map
	localparam reg_addr_t reg_addr_width = 1'b0;
	localparam reg_addr_t reg_addr_height = 1'b1;

endpackage

//--- verilog/noise_pkg.sv
// Noise estimation definitions
// Statistics widths, sample and block result structs
// Frame configuration bundle and the estimator states
package noise_pkg;

	// 64 samples of up to 255
	typedef logic [13:0] sum_t;

	// 64 squares of up to 65025
	typedef logic [21:0] sum_sq_t;

	typedef logic [15:0] variance_t;

	typedef struct packed {
		logic sof;
		video_pkg::luma_t luma;
	} luma_sample_t;

	typedef struct packed {
		video_pkg::dim_t width;
		video_pkg::dim_t height;
		video_pkg::block_count_t blocks;
	} frame_cfg_t;

	typedef struct packed {
		variance_t variance;
	} block_result_t;

	typedef enum logic [1:0] {
		idle,
		collect,
		report
	} estimator_state_t;

endpackage

//--- verilog/frame_config_regs.sv
// Frame configuration register file
// Width and height registers, write strobe and combinational read port
// Registered block count derived from the frame size
`timescale 1ns/1ns

module frame_config_regs (
	input logic clk,
	input logic reset,
	input logic reg_wr_en,
	input video_pkg::reg_addr_t reg_addr,
	input video_pkg::dim_t reg_wdata,
	input video_pkg::reg_addr_t reg_rd_addr,
	output video_pkg::dim_t reg_rdata,
	output noise_pkg::frame_cfg_t cfg
);
	import video_pkg::*;

	dim_t width_reg;
	dim_t height_reg;
	block_count_t blocks_reg;

	always_ff @(posedge clk) begin
		if (reset) begin
			width_reg <= '0;
			height_reg <= '0;
		end else if (reg_wr_en) begin
			case (reg_addr)
				reg_addr_width: width_reg <= reg_wdata;
				reg_addr_height: height_reg <= reg_wdata;
				default: width_reg <= width_reg;
			endcase
		end
	end

	// Follows the dimensions one cycle later
	always_ff @(posedge clk) begin
		if (reset) begin
			blocks_reg <= '0;
		end else begin
			blocks_reg <= (block_count_t'(width_reg) * block_count_t'(height_reg))
				>> block_shift;
		end
	end

	assign reg_rdata = (reg_rd_addr == reg_addr_width) ? width_reg : height_reg;

	assign cfg = '{width: width_reg, height: height_reg, blocks: blocks_reg};

endmodule

//--- verilog/pixel_ingest.sv
// Stream input stage
// Ready generation, word acceptance and start of frame tagging
// RGB to luma reduction, floor of the channel sum over three
`timescale 1ns/1ns

module pixel_ingest (
	input logic clk,
	input logic reset,
	input video_pkg::pixel_t s_axis_tdata,
	input logic s_axis_tvalid,
	input logic s_axis_tuser,
	output logic s_axis_tready,
	output noise_pkg::luma_sample_t sample,
	output logic sample_valid
);
	import video_pkg::*;

	logic accept;
	logic [9:0] rgb_sum;

	assign accept = s_axis_tvalid & s_axis_tready;

	// Up to 765, needs ten bits
	assign rgb_sum = 10'(s_axis_tdata[red_lsb +: channel_width])
		+ 10'(s_axis_tdata[green_lsb +: channel_width])
		+ 10'(s_axis_tdata[blue_lsb +: channel_width]);

	// No back-pressure, ready only drops in reset
	always_ff @(posedge clk) begin
		if (reset) begin
			s_axis_tready <= 1'b0;
		end else begin
			s_axis_tready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sample.luma <= luma_t'(rgb_sum / 10'd3);
			sample.sof <= s_axis_tuser;
		end
	end

	// Every sample comes from a word taken the cycle before
	assert property (@(posedge clk) disable iff (reset)
		sample_valid |-> $past(accept))
	else
		$error("sample_valid without an accepted stream word");

endmodule

//--- verilog/block_stats.sv
// Per-block statistics
// Sample counting, sum and sum of squares accumulation
// Variance stage, mean of squares minus squared mean
// Start of frame forwarding aligned with the block results
`timescale 1ns/1ns

module block_stats (
	input logic clk,
	input logic reset,
	input noise_pkg::luma_sample_t sample,
	input logic sample_valid,
	output logic frame_start,
	output noise_pkg::block_result_t result,
	output logic result_valid
);
	import video_pkg::*;
	import noise_pkg::*;

	logic [block_shift-1:0] sample_count;
	logic last_sample;
	logic [15:0] luma_sq;
	sum_t acc_sum;
	sum_sq_t acc_sum_sq;

	sum_t blk_sum;
	sum_sq_t blk_sum_sq;
	logic blk_valid;
	logic sof_d1;

	luma_t blk_mean;
	variance_t blk_mean_sq;
	variance_t mean_squared;

	assign luma_sq = sample.luma * sample.luma;
	assign last_sample = (sample_count == samples_per_block - 1);

	// A start of frame sample opens a fresh block
	always_ff @(posedge clk) begin
		if (reset) begin
			sample_count <= '0;
			acc_sum <= '0;
			acc_sum_sq <= '0;
		end else if (sample_valid) begin
			if (sample.sof) begin
				sample_count <= block_shift'(1);
				acc_sum <= sum_t'(sample.luma);
				acc_sum_sq <= sum_sq_t'(luma_sq);
			end else if (last_sample) begin
				sample_count <= '0;
				acc_sum <= '0;
				acc_sum_sq <= '0;
			end else begin
				sample_count <= sample_count + 1'b1;
				acc_sum <= acc_sum + sum_t'(sample.luma);
				acc_sum_sq <= acc_sum_sq + sum_sq_t'(luma_sq);
			end
		end
	end

	// Stage one, add the 64th sample and hand the block over
	always_ff @(posedge clk) begin
		if (sample_valid && last_sample) begin
			blk_sum <= acc_sum + sum_t'(sample.luma);
			blk_sum_sq <= acc_sum_sq + sum_sq_t'(luma_sq);
		end
	end

	assign blk_mean = luma_t'(blk_sum >> block_shift);
	assign blk_mean_sq = variance_t'(blk_sum_sq >> block_shift);
	assign mean_squared = blk_mean * blk_mean;

	// Stage two, variance of the handed over block
	always_ff @(posedge clk) begin
		if (blk_valid) begin
			result.variance <= blk_mean_sq - mean_squared;
		end
	end

	// Frame start delayed to the same two stages
	always_ff @(posedge clk) begin
		if (reset) begin
			blk_valid <= 1'b0;
			result_valid <= 1'b0;
			sof_d1 <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			blk_valid <= sample_valid & last_sample & ~sample.sof;
			result_valid <= blk_valid;
			sof_d1 <= sample_valid & sample.sof;
			frame_start <= sof_d1;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		blk_valid |-> (blk_mean_sq >= mean_squared))
	else
		$error("mean of squares below squared mean");

endmodule

//--- verilog/noise_estimator.sv
// Frame level noise estimator
// FSM that follows a frame from start to its last block
// Minimum block variance tracking and the ready pulse
`timescale 1ns/1ns

module noise_estimator (
	input logic clk,
	input logic reset,
	input noise_pkg::frame_cfg_t cfg,
	input logic frame_start,
	input noise_pkg::block_result_t result,
	input logic result_valid,
	output noise_pkg::variance_t estimated_noise,
	output logic estimated_noise_ready
);
	import video_pkg::*;
	import noise_pkg::*;

	estimator_state_t state;
	block_count_t blk_count;
	block_count_t blk_count_next;
	variance_t min_var;
	variance_t min_next;
	logic take_result;
	logic frame_done;

	assign blk_count_next = blk_count + block_count_t'(1);
	assign min_next = (result.variance < min_var) ? result.variance : min_var;

	// A restart wins over a late result
	assign take_result = (state == collect) && result_valid && !frame_start;
	assign frame_done = take_result && (blk_count_next == cfg.blocks);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			blk_count <= '0;
		end else begin
			case (state)
				idle: begin
					if (frame_start) begin
						state <= collect;
						blk_count <= '0;
					end
				end
				collect: begin
					if (frame_start) begin
						blk_count <= '0;
					end else if (take_result) begin
						blk_count <= blk_count_next;
						if (frame_done)
							state <= report;
					end
				end
				// Next frame may already be starting here
				report: begin
					if (frame_start) begin
						state <= collect;
						blk_count <= '0;
					end else begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (frame_start)
			min_var <= '1;
		else if (take_result)
			min_var <= min_next;
		if (frame_done)
			estimated_noise <= min_next;
	end

	assign estimated_noise_ready = (state == report);

	assert property (@(posedge clk) disable iff (reset)
		estimated_noise_ready |=> !estimated_noise_ready)
	else
		$error("estimated_noise_ready high for two cycles");

endmodule

//--- verilog/noise_top.sv
// Noise estimation top level
// Register file, stream ingest, block statistics and frame estimator
`timescale 1ns/1ns

module noise_top (
	input logic clk,
	input logic reset,
	input logic reg_wr_en,
	input video_pkg::reg_addr_t reg_addr,
	input video_pkg::dim_t reg_wdata,
	input video_pkg::reg_addr_t reg_rd_addr,
	output video_pkg::dim_t reg_rdata,
	input video_pkg::pixel_t s_axis_tdata,
	input logic s_axis_tvalid,
	input logic s_axis_tuser,
	output logic s_axis_tready,
	output noise_pkg::variance_t estimated_noise,
	output logic estimated_noise_ready
);
	import noise_pkg::*;

	frame_cfg_t cfg;
	luma_sample_t sample;
	logic sample_valid;
	logic frame_start;
	block_result_t result;
	logic result_valid;

	frame_config_regs u_regs (
		.clk(clk),
		.reset(reset),
		.reg_wr_en(reg_wr_en),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rd_addr(reg_rd_addr),
		.reg_rdata(reg_rdata),
		.cfg(cfg)
	);

	pixel_ingest u_ingest (
		.clk(clk),
		.reset(reset),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tready(s_axis_tready),
		.sample(sample),
		.sample_valid(sample_valid)
	);

	block_stats u_stats (
		.clk(clk),
		.reset(reset),
		.sample(sample),
		.sample_valid(sample_valid),
		.frame_start(frame_start),
		.result(result),
		.result_valid(result_valid)
	);

	noise_estimator u_estimator (
		.clk(clk),
		.reset(reset),
		.cfg(cfg),
		.frame_start(frame_start),
		.result(result),
		.result_valid(result_valid),
		.estimated_noise(estimated_noise),
		.estimated_noise_ready(estimated_noise_ready)
	);

endmodule

//--- sim/noise_tb.sv
// Testbench for the noise estimation top level
// Clock, reset, register access and pixel stream stimulus
// Reference noise model and compare tasks for registers and results
`timescale 1ns/1ns

module noise_tb;
	import video_pkg::*;
	import noise_pkg::*;

	localparam int timeout_cycles = 4000;

	logic clk;
	logic reset;
	logic reg_wr_en;
	reg_addr_t reg_addr;
	dim_t reg_wdata;
	reg_addr_t reg_rd_addr;
	dim_t reg_rdata;
	pixel_t s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tuser;
	logic s_axis_tready;
	variance_t estimated_noise;
	logic estimated_noise_ready;

	pixel_t frame_q[$];
	variance_t expected_q[$];
	variance_t expected_head;
	int reports_seen;

	noise_top uut (
		.clk(clk),
		.reset(reset),
		.reg_wr_en(reg_wr_en),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rd_addr(reg_rd_addr),
		.reg_rdata(reg_rdata),
		.s_axis_tdata(s_axis_tdata),
		.s_axis_tvalid(s_axis_tvalid),
		.s_axis_tuser(s_axis_tuser),
		.s_axis_tready(s_axis_tready),
		.estimated_noise(estimated_noise),
		.estimated_noise_ready(estimated_noise_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Minimum over blocks of floor(mean of squares) minus floor(mean) squared
	function automatic variance_t ref_noise(input pixel_t px[$], input dim_t w, input dim_t h);
		int blocks;
		int b;
		int k;
		int l;
		int sum;
		int sum_sq;
		int var_v;
		pixel_t p;
		variance_t min_v;
		blocks = (int'(w) * int'(h)) / 64;
		min_v = 16'hffff;
		for (b = 0; b < blocks; b++) begin
			sum = 0;
			sum_sq = 0;
			for (k = 0; k < 64; k++) begin
				p = px[b * 64 + k];
				l = (int'(p[23:16]) + int'(p[15:8]) + int'(p[7:0])) / 3;
				sum += l;
				sum_sq += l * l;
			end
			var_v = sum_sq / 64 - (sum / 64) * (sum / 64);
			if (var_v < int'(min_v))
				min_v = variance_t'(var_v);
		end
		return min_v;
	endfunction

	task automatic check_dim(input string name, input dim_t got, input dim_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "register value mismatch");
		end
	endtask

	task automatic check_noise(input string name, input variance_t got, input variance_t exp);
		if (got !== exp) begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			$display("Checks failed");
			$fatal(1, "noise value mismatch");
		end
	endtask

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1, "run stopped");
	endtask

	// Compares each reported estimate with the oldest outstanding frame
	always @(negedge clk) begin
		if (estimated_noise_ready) begin
			if (expected_q.size() == 0) begin
				abort_run("noise result reported with no frame outstanding");
			end else begin
				expected_head = expected_q.pop_front();
				check_noise("estimated_noise", estimated_noise, expected_head);
				reports_seen = reports_seen + 1;
			end
		end
	end

	task automatic write_reg(input reg_addr_t addr, input dim_t data);
		@(posedge clk);
		reg_wr_en <= 1'b1;
		reg_addr <= addr;
		reg_wdata <= data;
		@(posedge clk);
		reg_wr_en <= 1'b0;
	endtask

	task automatic read_check(input reg_addr_t addr, input dim_t exp);
		@(posedge clk);
		reg_rd_addr <= addr;
		@(negedge clk);
		check_dim("reg_rdata", reg_rdata, exp);
	endtask

	task automatic wait_accept();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!s_axis_tready && n < timeout_cycles);
		if (!s_axis_tready)
			abort_run("stream word was never accepted");
	endtask

	task automatic send_frame(input bit gaps);
		int i;
		int gap_cycles;
		@(posedge clk);
		for (i = 0; i < frame_q.size(); i++) begin
			if (gaps) begin
				gap_cycles = $urandom_range(3, 0);
				s_axis_tvalid <= 1'b0;
				s_axis_tuser <= 1'b0;
				repeat (gap_cycles) @(posedge clk);
			end
			s_axis_tdata <= frame_q[i];
			s_axis_tvalid <= 1'b1;
			s_axis_tuser <= (i == 0);
			wait_accept();
		end
		s_axis_tvalid <= 1'b0;
		s_axis_tuser <= 1'b0;
	endtask

	task automatic wait_reports(input int target);
		int n;
		n = 0;
		while (reports_seen < target && n < timeout_cycles) begin
			@(posedge clk);
			n++;
		end
		if (reports_seen < target)
			abort_run("no noise result arrived before the timeout");
	endtask

	// Flat frames have zero variance in every block
	task automatic run_frame(input dim_t w, input dim_t h, input bit flat, input bit gaps);
		int i;
		int target;
		write_reg(reg_addr_width, w);
		write_reg(reg_addr_height, h);
		frame_q.delete();
		for (i = 0; i < int'(w) * int'(h); i++)
			frame_q.push_back(flat ? 32'h0040_80c0 : $urandom);
		if (flat)
			expected_q.push_back(variance_t'(0));
		else
			expected_q.push_back(ref_noise(frame_q, w, h));
		target = reports_seen + 1;
		send_frame(gaps);
		wait_reports(target);
	endtask

	initial begin
		int n;
		void'($urandom(32'h0b20a479));
		reset = 1'b1;
		reg_wr_en = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		reg_rd_addr = '0;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		s_axis_tuser = 1'b0;
		reports_seen = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		n = 0;
		while (!s_axis_tready && n < timeout_cycles) begin
			@(posedge clk);
			n++;
		end
		if (!s_axis_tready)
			abort_run("stream ready never rose after reset");

		write_reg(reg_addr_width, 16'd16);
		write_reg(reg_addr_height, 16'd8);
		read_check(reg_addr_width, 16'd16);
		read_check(reg_addr_height, 16'd8);

		run_frame(16'd16, 16'd8, 1'b1, 1'b0);
		// A second pulse here finds no frame outstanding
		repeat (40) @(posedge clk);

		run_frame(16'd16, 16'd16, 1'b0, 1'b0);
		run_frame(16'd16, 16'd16, 1'b0, 1'b1);

		// Dimensions change between consecutive frames
		run_frame(16'd16, 16'd8, 1'b0, 1'b0);
		run_frame(16'd8, 16'd24, 1'b0, 1'b0);

		repeat (20) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- filelist.f
verilog/video_pkg.sv
verilog/noise_pkg.sv
verilog/frame_config_regs.sv
verilog/pixel_ingest.sv
verilog/block_stats.sv
verilog/noise_estimator.sv
verilog/noise_top.sv
sim/noise_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the noise estimation testbench with Verilator and run it.
# The exit status is the simulator's own status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module noise_tb \
	--Mdir obj_dir
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit "$build_status"
fi

./obj_dir/Vnoise_tb
run_status=$?
if [ "$run_status" -ne 0 ]; then
	echo "Simulation failed with status $run_status"
	exit "$run_status"
fi

echo "Simulation finished with status 0"
exit 0
